//--- hw/cache_pkg.sv
// address layout constants, way count, address field struct and address union
package cache_pkg;

    // word address is tag | index | offset
    localparam int ADDR_WIDTH   = 16;
    localparam int OFFSET_WIDTH = 2;
    localparam int INDEX_WIDTH  = 4;
    localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    // four words per block
    localparam int BLOCK_WORDS = 1 << OFFSET_WIDTH;

    // one LRU bit per set assumes exactly two ways
    localparam int NUM_WAYS = 2;

    localparam int num_sets = 1 << INDEX_WIDTH;

    typedef struct packed {
        logic [TAG_WIDTH-1:0]    tag;
        logic [INDEX_WIDTH-1:0]  index;
        logic [OFFSET_WIDTH-1:0] offset;
    } addr_fields_t;

    // raw for ports and write-back address, fields for lookup
    typedef union packed {
        logic [ADDR_WIDTH-1:0] raw;
        addr_fields_t          fields;
    } cache_addr_u;

endpackage

//--- hw/cache_req_stage.sv
// cache_req_stage: request capture register and address split for the ways
`timescale 1ns/1ps

module cache_req_stage #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 req,
    input  logic [cache_pkg::ADDR_WIDTH-1:0]     req_addr,
    input  logic                                 req_write,
    input  logic [DATA_WIDTH-1:0]                req_wdata,

    output logic                                 look_valid,
    output logic                                 look_write,
    output logic [cache_pkg::TAG_WIDTH-1:0]      look_tag,
    output logic [cache_pkg::INDEX_WIDTH-1:0]    look_index,
    output logic [cache_pkg::OFFSET_WIDTH-1:0]   look_offset,
    output logic [DATA_WIDTH-1:0]                look_wdata
);

    cache_pkg::cache_addr_u look_addr;

    // strobe and write flag
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            look_valid <= 1'b0;
            look_write <= 1'b0;
        end else begin
            look_valid <= req;
            look_write <= req & req_write;
        end
    end

    // address and data held until the next request
    always_ff @(posedge clk) begin
        if (req) begin
            look_addr.raw <= req_addr;
            look_wdata    <= req_wdata;
        end
    end

    // split for lookup
    assign look_tag    = look_addr.fields.tag;
    assign look_index  = look_addr.fields.index;
    assign look_offset = look_addr.fields.offset;

    // the ways and the victim stage qualify everything with this strobe
    look_valid_known: assert property (
        @(posedge clk) disable iff (reset)
        !$isunknown(look_valid)
    ) else $error("look_valid is unknown after reset");

endmodule

//--- hw/cache_way.sv
// cache_way: one way's tag, valid, dirty and block arrays with tag compare and update
`timescale 1ns/1ps

module cache_way #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                                          clk,
    input  logic                                          reset,
    input  logic [cache_pkg::TAG_WIDTH-1:0]               look_tag,
    input  logic [cache_pkg::INDEX_WIDTH-1:0]             look_index,
    input  logic [cache_pkg::OFFSET_WIDTH-1:0]            look_offset,
    input  logic [DATA_WIDTH-1:0]                         look_wdata,
    input  logic                                          write_hit,
    input  logic                                          alloc,
    input  logic                                          look_write,

    output logic                                          way_hit,
    output logic                                          way_valid,
    output logic                                          way_dirty,
    output logic [cache_pkg::TAG_WIDTH-1:0]               way_tag,
    output logic [cache_pkg::BLOCK_WORDS*DATA_WIDTH-1:0]  way_block
);

    // per-set arrays
    logic [cache_pkg::TAG_WIDTH-1:0] tag_mem [cache_pkg::num_sets];
    logic [cache_pkg::BLOCK_WORDS-1:0][DATA_WIDTH-1:0] data_mem [cache_pkg::num_sets];
    logic [cache_pkg::num_sets-1:0] valid_bits;
    logic [cache_pkg::num_sets-1:0] dirty_bits;

    logic [cache_pkg::BLOCK_WORDS-1:0][DATA_WIDTH-1:0] cur_block;
    logic [cache_pkg::BLOCK_WORDS-1:0][DATA_WIDTH-1:0] new_block;

    // addressed set, read combinationally during lookup
    assign cur_block = data_mem[look_index];
    assign way_valid = valid_bits[look_index];
    assign way_dirty = dirty_bits[look_index];
    assign way_tag   = tag_mem[look_index];
    assign way_block = cur_block;
    assign way_hit   = way_valid && (way_tag == look_tag);

    // allocation starts from an empty block, no refill
    always_comb begin
        new_block = alloc ? '0 : cur_block;
        if (look_write) begin
            new_block[look_offset] = look_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (write_hit || alloc) begin
            data_mem[look_index] <= new_block;
        end
        if (alloc) begin
            tag_mem[look_index] <= look_tag;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            if (alloc) begin
                valid_bits[look_index] <= 1'b1;
                dirty_bits[look_index] <= look_write;
            end else if (write_hit) begin
                dirty_bits[look_index] <= 1'b1;
            end
        end
    end

    // victim stage must never ask for both on the same way
    strobes_exclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(write_hit && alloc)
    ) else $error("write_hit and alloc high together");

endmodule

//--- hw/cache_victim_select.sv
// hit merge, LRU bits, victim choice, read mux, strobes and write-back
`timescale 1ns/1ps

module cache_victim_select #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         look_valid,
    input  logic                                         look_write,
    input  logic [cache_pkg::INDEX_WIDTH-1:0]            look_index,
    input  logic [cache_pkg::OFFSET_WIDTH-1:0]           look_offset,
    input  logic [DATA_WIDTH-1:0]                        look_wdata,
    input  logic [cache_pkg::NUM_WAYS-1:0]               way_hit,
    input  logic [cache_pkg::NUM_WAYS-1:0]               way_valid,
    input  logic [cache_pkg::NUM_WAYS-1:0]               way_dirty,
    input  logic [cache_pkg::NUM_WAYS-1:0][cache_pkg::TAG_WIDTH-1:0] way_tag,
    input  logic [cache_pkg::NUM_WAYS-1:0][cache_pkg::BLOCK_WORDS*DATA_WIDTH-1:0] way_block,

    output logic [cache_pkg::NUM_WAYS-1:0]               write_hit,
    output logic [cache_pkg::NUM_WAYS-1:0]               alloc,
    output logic                                         resp_valid,
    output logic                                         resp_hit,
    output logic [DATA_WIDTH-1:0]                        resp_rdata,
    output logic                                         write_back,
    output logic [cache_pkg::ADDR_WIDTH-cache_pkg::OFFSET_WIDTH-1:0] wb_addr,
    output logic [cache_pkg::BLOCK_WORDS*DATA_WIDTH-1:0] wb_data
);

    localparam int WAY_BITS = $clog2(cache_pkg::NUM_WAYS);

    // bit names the way to evict next
    logic [cache_pkg::num_sets-1:0] lru_bits;

    logic                 any_hit;
    logic                 miss;
    logic                 evict;
    logic [WAY_BITS-1:0]  hit_way;
    logic [WAY_BITS-1:0]  victim;
    logic [WAY_BITS-1:0]  used_way;
    logic [DATA_WIDTH-1:0] rd_word;
    logic [cache_pkg::BLOCK_WORDS-1:0][DATA_WIDTH-1:0] hit_block;
    cache_pkg::cache_addr_u wb_line;

    assign any_hit = look_valid && (|way_hit);
    assign miss    = look_valid && !(|way_hit);

    // first invalid way wins, otherwise LRU
    always_comb begin
        hit_way = '0;
        victim  = lru_bits[look_index];
        for (int w = cache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            if (way_hit[w]) begin
                hit_way = WAY_BITS'(w);
            end
            if (!way_valid[w]) begin
                victim = WAY_BITS'(w);
            end
        end
    end

    assign used_way = any_hit ? hit_way : victim;
    assign evict    = miss && way_valid[victim] && way_dirty[victim];

    // write hits answer with the word as it was before the write
    assign hit_block = way_block[hit_way];
    assign rd_word   = any_hit ? hit_block[look_offset] : '0;

    always_comb begin
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
            write_hit[w] = any_hit && look_write && (hit_way == WAY_BITS'(w));
            alloc[w]     = miss && (victim == WAY_BITS'(w));
        end
    end

    // evicted line address is tag and index without the offset
    always_comb begin
        wb_line.fields.tag    = way_tag[victim];
        wb_line.fields.index  = look_index;
        wb_line.fields.offset = '0;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lru_bits <= '0;
        end else if (look_valid) begin
            lru_bits[look_index] <= ~used_way;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            resp_valid <= 1'b0;
            resp_hit   <= 1'b0;
            write_back <= 1'b0;
        end else begin
            resp_valid <= look_valid;
            resp_hit   <= any_hit;
            write_back <= evict;
        end
    end

    always_ff @(posedge clk) begin
        resp_rdata <= rd_word;
        if (evict) begin
            wb_addr <= wb_line.raw[cache_pkg::ADDR_WIDTH-1:cache_pkg::OFFSET_WIDTH];
            wb_data <= way_block[victim];
        end
    end

    // a tag lives in at most one way of a set
    single_hit: assert property (
        @(posedge clk) disable iff (reset)
        look_valid |-> $onehot0(way_hit)
    ) else $error("more than one way hit in set %0d", look_index);

    // a hit write must carry known data
    wdata_known: assert property (
        @(posedge clk) disable iff (reset)
        (|write_hit) |-> !$isunknown(look_wdata)
    ) else $error("write hit with unknown write data");

endmodule

//--- hw/cache_top.sv
// cache_top: request stage, two cache ways and the victim/response stage
`timescale 1ns/1ps

module cache_top #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         req,
    input  logic [cache_pkg::ADDR_WIDTH-1:0]             req_addr,
    input  logic                                         req_write,
    input  logic [DATA_WIDTH-1:0]                        req_wdata,

    output logic                                         resp_valid,
    output logic                                         resp_hit,
    output logic [DATA_WIDTH-1:0]                        resp_rdata,
    output logic                                         write_back,
    output logic [cache_pkg::ADDR_WIDTH-cache_pkg::OFFSET_WIDTH-1:0] wb_addr,
    output logic [cache_pkg::BLOCK_WORDS*DATA_WIDTH-1:0] wb_data
);

    // lookup stage signals
    logic                                 look_valid;
    logic                                 look_write;
    logic [cache_pkg::TAG_WIDTH-1:0]      look_tag;
    logic [cache_pkg::INDEX_WIDTH-1:0]    look_index;
    logic [cache_pkg::OFFSET_WIDTH-1:0]   look_offset;
    logic [DATA_WIDTH-1:0]                look_wdata;

    // per-way status and strobes
    logic [cache_pkg::NUM_WAYS-1:0]       way_hit;
    logic [cache_pkg::NUM_WAYS-1:0]       way_valid;
    logic [cache_pkg::NUM_WAYS-1:0]       way_dirty;
    logic [cache_pkg::NUM_WAYS-1:0][cache_pkg::TAG_WIDTH-1:0] way_tag;
    logic [cache_pkg::NUM_WAYS-1:0][cache_pkg::BLOCK_WORDS*DATA_WIDTH-1:0] way_block;
    logic [cache_pkg::NUM_WAYS-1:0]       write_hit;
    logic [cache_pkg::NUM_WAYS-1:0]       alloc;

    cache_req_stage #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_req_stage (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .req_addr    (req_addr),
        .req_write   (req_write),
        .req_wdata   (req_wdata),
        .look_valid  (look_valid),
        .look_write  (look_write),
        .look_tag    (look_tag),
        .look_index  (look_index),
        .look_offset (look_offset),
        .look_wdata  (look_wdata)
    );

    for (genvar w = 0; w < cache_pkg::NUM_WAYS; w++) begin : g_way
        cache_way #(
            .DATA_WIDTH (DATA_WIDTH)
        ) u_way (
            .clk         (clk),
            .reset       (reset),
            .look_tag    (look_tag),
            .look_index  (look_index),
            .look_offset (look_offset),
            .look_wdata  (look_wdata),
            .write_hit   (write_hit[w]),
            .alloc       (alloc[w]),
            .look_write  (look_write),
            .way_hit     (way_hit[w]),
            .way_valid   (way_valid[w]),
            .way_dirty   (way_dirty[w]),
            .way_tag     (way_tag[w]),
            .way_block   (way_block[w])
        );
    end

    cache_victim_select #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_victim_select (
        .clk         (clk),
        .reset       (reset),
        .look_valid  (look_valid),
        .look_write  (look_write),
        .look_index  (look_index),
        .look_offset (look_offset),
        .look_wdata  (look_wdata),
        .way_hit     (way_hit),
        .way_valid   (way_valid),
        .way_dirty   (way_dirty),
        .way_tag     (way_tag),
        .way_block   (way_block),
        .write_hit   (write_hit),
        .alloc       (alloc),
        .resp_valid  (resp_valid),
        .resp_hit    (resp_hit),
        .resp_rdata  (resp_rdata),
        .write_back  (write_back),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data)
    );

endmodule

//--- testbench/cache_checker.sv
// reference cache model, response and write-back comparison, per-test and total counts
`timescale 1ns/1ps

module cache_checker #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         req,
    input  logic [cache_pkg::ADDR_WIDTH-1:0]             req_addr,
    input  logic                                         req_write,
    input  logic [DATA_WIDTH-1:0]                        req_wdata,
    input  int                                           req_hint,
    input  logic                                         resp_valid,
    input  logic                                         resp_hit,
    input  logic [DATA_WIDTH-1:0]                        resp_rdata,
    input  logic                                         write_back,
    input  logic [cache_pkg::ADDR_WIDTH-cache_pkg::OFFSET_WIDTH-1:0] wb_addr,
    input  logic [cache_pkg::BLOCK_WORDS*DATA_WIDTH-1:0] wb_data,
    input  logic                                         test_end,
    input  int                                           end_test,
    input  logic                                         finish_run,
    output int                                           error_count,
    output int                                           check_count,
    output logic                                         summary_done
);

    localparam int AW = cache_pkg::ADDR_WIDTH;
    localparam int IW = cache_pkg::INDEX_WIDTH;
    localparam int OW = cache_pkg::OFFSET_WIDTH;
    localparam int BW = cache_pkg::BLOCK_WORDS * DATA_WIDTH;
    localparam int QD = 256;

    // model of both ways
    logic [AW-IW-OW-1:0]            m_tag  [2][cache_pkg::num_sets];
    logic [DATA_WIDTH-1:0]          m_data [2][cache_pkg::num_sets][cache_pkg::BLOCK_WORDS];
    logic [cache_pkg::num_sets-1:0] m_valid [2];
    logic [cache_pkg::num_sets-1:0] m_dirty [2];
    logic [cache_pkg::num_sets-1:0] m_lru;

    // expected responses in flight, head to tail
    int                    q_due     [QD];
    int                    q_hint    [QD];
    logic                  q_read    [QD];
    logic                  q_hit     [QD];
    logic                  q_wb      [QD];
    logic [DATA_WIDTH-1:0] q_rdata   [QD];
    logic [AW-OW-1:0]      q_wb_addr [QD];
    logic [BW-1:0]         q_wb_data [QD];
    int                    head;
    int                    tail;

    int cycle;
    int test_checks;
    int test_errors;

    task automatic check_value(input string name, input logic [BW-1:0] expected,
                               input logic [BW-1:0] actual);
        check_count++;
        test_checks++;
        if (actual !== expected) begin
            $display("error at %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("at %0d ns: %s", $time, what);
        error_count++;
        test_errors++;
    endtask

    task automatic model_access(input logic [AW-1:0] addr, input logic wr,
                                input logic [DATA_WIDTH-1:0] wdata, input int hint);
        logic [AW-IW-OW-1:0] tag;
        logic [IW-1:0]       idx;
        logic [OW-1:0]       off;
        logic                hit0;
        logic                hit1;
        logic                way;
        logic [BW-1:0]       old_block;
        tag  = addr[AW-1:IW+OW];
        idx  = addr[IW+OW-1:OW];
        off  = addr[OW-1:0];
        hit0 = m_valid[0][idx] && (m_tag[0][idx] == tag);
        hit1 = m_valid[1][idx] && (m_tag[1][idx] == tag);
        // on a miss, first invalid way, else the LRU way
        if (hit0 || hit1) begin
            way = hit1;
        end else if (!m_valid[0][idx]) begin
            way = 1'b0;
        end else if (!m_valid[1][idx]) begin
            way = 1'b1;
        end else begin
            way = m_lru[idx];
        end
        for (int k = 0; k < cache_pkg::BLOCK_WORDS; k++) begin
            old_block[k*DATA_WIDTH +: DATA_WIDTH] = m_data[way][idx][k];
        end
        q_due[tail]     = cycle + 2;
        q_hint[tail]    = hint;
        q_read[tail]    = !wr;
        q_hit[tail]     = hit0 || hit1;
        q_rdata[tail]   = (hit0 || hit1) ? m_data[way][idx][off] : '0;
        q_wb[tail]      = !(hit0 || hit1) && m_valid[way][idx] && m_dirty[way][idx];
        q_wb_addr[tail] = {m_tag[way][idx], idx};
        q_wb_data[tail] = old_block;
        tail++;
        if (!(hit0 || hit1)) begin
            // missing block reads as zero
            for (int k = 0; k < cache_pkg::BLOCK_WORDS; k++) begin
                m_data[way][idx][k] = '0;
            end
            m_tag[way][idx]   = tag;
            m_valid[way][idx] = 1'b1;
            m_dirty[way][idx] = wr;
        end else if (wr) begin
            m_dirty[way][idx] = 1'b1;
        end
        if (wr) begin
            m_data[way][idx][off] = wdata;
        end
        m_lru[idx] = !way;
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (reset) begin
            m_valid[0]   = '0;
            m_valid[1]   = '0;
            m_dirty[0]   = '0;
            m_dirty[1]   = '0;
            m_lru        = '0;
            head         = 0;
            tail         = 0;
            cycle        = 0;
            error_count  = 0;
            check_count  = 0;
            test_checks  = 0;
            test_errors  = 0;
            summary_done = 1'b0;
        end else begin
            cycle++;
            if (head < tail && q_due[head] == cycle) begin
                if (!resp_valid) begin
                    report_failure("response missing two cycles after a request");
                end else begin
                    check_value("resp_hit", BW'(q_hit[head]), BW'(resp_hit));
                    if (q_hint[head] < 2) begin
                        check_value("resp_hit vs table", BW'(q_hint[head]), BW'(resp_hit));
                    end
                    if (q_read[head]) begin
                        check_value("resp_rdata", BW'(q_rdata[head]), BW'(resp_rdata));
                    end
                end
                if (q_wb[head] != write_back) begin
                    report_failure(q_wb[head] ? "write_back missing on a dirty eviction"
                                              : "write_back pulsed without a dirty eviction");
                end else if (q_wb[head]) begin
                    check_value("wb_addr", BW'(q_wb_addr[head]), BW'(wb_addr));
                    check_value("wb_data", q_wb_data[head], wb_data);
                end
                head++;
            end else if (resp_valid || write_back) begin
                report_failure("resp_valid or write_back high with no request due");
            end
            if (req) begin
                model_access(req_addr, req_write, req_wdata, req_hint);
            end
            if (test_end) begin
                $display("test %0d done: %0d checks, %0d errors",
                         end_test, test_checks, test_errors);
                test_checks = 0;
                test_errors = 0;
            end
            if (finish_run && !summary_done) begin
                if (head != tail) begin
                    report_failure("responses still outstanding at the end of the run");
                end
                $display("total: %0d checks, %0d errors", check_count, error_count);
                summary_done = 1'b1;
            end
        end
    end

endmodule

//--- testbench/cache_tb.sv
// testbench top: clock, reset, watchdog, stimulus table and the loop that applies it
`timescale 1ns/1ps

module cache_tb;

    localparam int DATA_WIDTH   = 32;
    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 10;
    localparam int GAP          = 4;
    localparam int NUM_TESTS    = 6;
    localparam int MAX_ENTRIES  = 64;
    localparam int TW           = cache_pkg::TAG_WIDTH;
    localparam int IW           = cache_pkg::INDEX_WIDTH;
    localparam int OW           = cache_pkg::OFFSET_WIDTH;
    localparam logic RD         = 1'b0;
    localparam logic WR         = 1'b1;

    logic                                         clk;
    logic                                         reset;
    logic                                         req;
    logic [cache_pkg::ADDR_WIDTH-1:0]             req_addr;
    logic                                         req_write;
    logic [DATA_WIDTH-1:0]                        req_wdata;
    logic                                         resp_valid;
    logic                                         resp_hit;
    logic [DATA_WIDTH-1:0]                        resp_rdata;
    logic                                         write_back;
    logic [TW+IW-1:0]                             wb_addr;
    logic [cache_pkg::BLOCK_WORDS*DATA_WIDTH-1:0] wb_data;

    int   req_hint;
    logic test_end;
    int   end_test;
    logic finish_run;
    int   error_count;
    int   check_count;
    logic summary_done;
    logic table_ready;
    int   seed;

    // stimulus table, hit 2 leaves the hit flag to the model alone
    logic                             tbl_write [MAX_ENTRIES];
    logic [cache_pkg::ADDR_WIDTH-1:0] tbl_addr  [MAX_ENTRIES];
    logic [DATA_WIDTH-1:0]            tbl_wdata [MAX_ENTRIES];
    int                               tbl_hit   [MAX_ENTRIES];
    int                               tbl_test  [MAX_ENTRIES];
    int                               num_entries;

    cache_top #(.DATA_WIDTH(DATA_WIDTH)) dut0 (.*);

    cache_checker #(.DATA_WIDTH(DATA_WIDTH)) check0 (.*);

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    function automatic logic [cache_pkg::ADDR_WIDTH-1:0] make_addr(int tag, int index, int offset);
        return {TW'(tag), IW'(index), OW'(offset)};
    endfunction

    task automatic add_entry(input logic wr, input int tag, input int index, input int offset,
                             input int hit, input int test);
        tbl_write[num_entries] = wr;
        tbl_addr[num_entries]  = make_addr(tag, index, offset);
        tbl_wdata[num_entries] = $random(seed);
        tbl_hit[num_entries]   = hit;
        tbl_test[num_entries]  = test;
        num_entries++;
    endtask

    task automatic build_table();
        num_entries = 0;
        // cold read, then hits in the same block
        add_entry(RD, 5, 1, 0, 0, 1);
        add_entry(RD, 5, 1, 0, 1, 1);
        add_entry(RD, 5, 1, 3, 1, 1);
        // write miss allocates
        add_entry(WR, 7, 2, 1, 0, 2);
        add_entry(RD, 7, 2, 1, 1, 2);
        add_entry(RD, 7, 2, 0, 1, 2);
        // write hits, latest value wins
        add_entry(WR, 7, 2, 1, 1, 3);
        add_entry(WR, 7, 2, 3, 1, 3);
        add_entry(WR, 7, 2, 1, 1, 3);
        add_entry(RD, 7, 2, 1, 1, 3);
        // set 3, the hit on tag 1 makes tag 2 the victim
        add_entry(RD, 1, 3, 0, 0, 4);
        add_entry(RD, 2, 3, 0, 0, 4);
        add_entry(RD, 1, 3, 0, 1, 4);
        add_entry(RD, 3, 3, 0, 0, 4);
        add_entry(RD, 1, 3, 0, 1, 4);
        add_entry(RD, 2, 3, 0, 0, 4);
        // dirty tag 1 evicted with write_back, then clean tag 2 without
        add_entry(WR, 1, 4, 0, 0, 5);
        add_entry(WR, 1, 4, 2, 1, 5);
        add_entry(WR, 1, 4, 3, 1, 5);
        add_entry(RD, 2, 4, 0, 0, 5);
        add_entry(RD, 3, 4, 0, 0, 5);
        add_entry(RD, 4, 4, 0, 0, 5);
        // random mix over sets 5 to 7, one request per cycle
        for (int i = 0; i < 40; i++) begin
            add_entry(($random(seed) % 2) != 0, $unsigned($random(seed)) % 4,
                      5 + $unsigned($random(seed)) % 3, $unsigned($random(seed)) % 4, 2, 6);
        end
    endtask

    initial begin
        reset       = 1'b1;
        req         = 1'b0;
        req_addr    = '0;
        req_write   = 1'b0;
        req_wdata   = '0;
        req_hint    = 2;
        test_end    = 1'b0;
        end_test    = 0;
        finish_run  = 1'b0;
        table_ready = 1'b0;
        seed        = 74459;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 reset = 1'b0;
        for (int i = 0; i < num_entries; i++) begin
            @(posedge clk);
            #2;
            req       = 1'b1;
            req_write = tbl_write[i];
            req_addr  = tbl_addr[i];
            req_wdata = tbl_wdata[i];
            req_hint  = tbl_hit[i];
            // idle gap drains the last response before the test is closed
            if (i == num_entries - 1 || tbl_test[i + 1] != tbl_test[i]) begin
                @(posedge clk);
                #2 req = 1'b0;
                repeat (GAP) @(posedge clk);
                #2;
                test_end = 1'b1;
                end_test = tbl_test[i];
                @(posedge clk);
                #2 test_end = 1'b0;
            end
        end
        finish_run = 1'b1;
        wait (summary_done);
        if (error_count == 0 && check_count > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // table length, per-test gaps and reset, plus margin
    initial begin
        wait (table_ready);
        #((num_entries + NUM_TESTS * (GAP + 3) + RESET_CYCLES + 20) * PERIOD);
        $display("watchdog: run did not finish in the expected time");
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- sources.f
hw/cache_pkg.sv
hw/cache_req_stage.sv
hw/cache_way.sv
hw/cache_victim_select.sv
hw/cache_top.sv
testbench/cache_checker.sv
testbench/cache_tb.sv

//--- Makefile
# Verilator build and run of the cache testbench

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the Verilator build directory"
	@echo "make help   list these targets"

test:
	verilator --binary --assert -j 0 --top-module cache_tb -f sources.f -Mdir obj_dir -o cache_sim
	@out="$$(./obj_dir/cache_sim)"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir
